/* hw/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // ----------------------------------------------------------------------
    // Fetch geometry
    // ----------------------------------------------------------------------

    // Instructions handed to the instruction buffer per bundle
    localparam int FETCH_WIDTH = 4;

    // Global history length kept by the branch predictor
    localparam int GHR_WIDTH = 8;

    // ----------------------------------------------------------------------
    // Datapath types
    // ----------------------------------------------------------------------

    // Byte address
    typedef logic [31:0] addr_t;

    // One RV32 instruction word
    typedef logic [31:0] inst_t;

    // Memory line, low word at the line address
    typedef logic [2*$bits(inst_t)-1:0] line_t;

    // Snapshot of the global branch history
    typedef logic [GHR_WIDTH-1:0] ghr_t;

    typedef logic [6:0] opcode_t;

    // ----------------------------------------------------------------------
    // RV32 opcodes
    // ----------------------------------------------------------------------

    // BEQ, BNE, BLT, BGE, BLTU, BGEU
    localparam opcode_t RV32_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

/* hw/inst_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_memory
    import fetch_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic  clock,
    input  logic  reset,

    // Program load, one word per cycle
    input  logic  load_enable,
    input  addr_t load_addr,
    input  inst_t load_data,

    // Two line read ports
    input  logic  read_valid,
    input  addr_t read_addr0,
    input  addr_t read_addr1,
    output line_t line0,
    output line_t line1,
    output logic  line_ready
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef logic [IDX_W-1:0] word_idx_t;

    inst_t mem [MEM_WORDS];

    // Request seen in the previous cycle
    addr_t last_addr0;
    addr_t last_addr1;
    logic  last_valid;

    // Array output, one cycle behind the request
    line_t line0_q;
    line_t line1_q;

    // Byte address to word slot, wrapping at the array depth
    function automatic word_idx_t word_index(addr_t addr);
        return word_idx_t'((addr >> 2) % MEM_WORDS);
    endfunction

    // Word at addr in the low half, addr + 4 in the high half
    function automatic line_t read_line(addr_t addr);
        return {mem[word_index(addr + 32'd4)], mem[word_index(addr)]};
    endfunction

    always_ff @(posedge clock) begin
        if (load_enable) begin
            mem[word_index(load_addr)] <= load_data;
        end
    end

    // ----------------------------------------------------------------------
    // Array access
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (read_valid) begin
            line0_q <= read_line(read_addr0);
            line1_q <= read_line(read_addr1);
        end
        last_addr0 <= read_addr0;
        last_addr1 <= read_addr1;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_valid <= 1'b0;
        end else begin
            last_valid <= read_valid;
        end
    end

    // Data is good once the same request has been held for a cycle
    assign line_ready = read_valid && last_valid &&
                        (last_addr0 == read_addr0) && (last_addr1 == read_addr1);

    assign line0 = line0_q;
    assign line1 = line1_q;

endmodule

`default_nettype wire

/* hw/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor
    import fetch_pkg::*;
#(
    parameter int BP_ENTRIES = 16
) (
    input  logic  clock,
    input  logic  reset,

    // Prediction request from fetch, answered in the same cycle
    input  logic  bp_req_valid,
    input  addr_t bp_req_pc,
    output logic  pred_taken,
    output addr_t pred_target,
    output ghr_t  pred_ghr,

    // Training from retire
    input  logic  update_valid,
    input  addr_t update_pc,
    input  logic  update_taken,
    input  addr_t update_target
);

    localparam int IDX_W = $clog2(BP_ENTRIES);

    typedef logic [IDX_W-1:0] bp_idx_t;
    typedef logic [1:0]       counter_t;

    // Counters start weakly not taken
    localparam counter_t CTR_INIT  = 2'd1;
    localparam counter_t CTR_MAX   = 2'd3;
    localparam counter_t CTR_TAKEN = 2'd2;

    counter_t              counters [BP_ENTRIES];
    addr_t                 targets  [BP_ENTRIES];
    logic [BP_ENTRIES-1:0] target_valid;
    ghr_t                  ghr;

    bp_idx_t req_idx;
    bp_idx_t upd_idx;

    // Word-aligned PCs, so index from bit 2 up
    assign req_idx = bp_req_pc[IDX_W+1:2];
    assign upd_idx = update_pc[IDX_W+1:2];

    // ----------------------------------------------------------------------
    // Predict
    // ----------------------------------------------------------------------

    always_comb begin
        pred_taken  = 1'b0;
        pred_target = '0;
        if (bp_req_valid && target_valid[req_idx]) begin
            pred_taken  = (counters[req_idx] >= CTR_TAKEN);
            pred_target = targets[req_idx];
        end
    end

    assign pred_ghr = ghr;

    // ----------------------------------------------------------------------
    // Update
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                counters[i] <= CTR_INIT;
            end
            target_valid <= '0;
            ghr          <= '0;
        end else if (update_valid) begin
            if (update_taken) begin
                if (counters[upd_idx] != CTR_MAX) begin
                    counters[upd_idx] <= counters[upd_idx] + 2'd1;
                end
                target_valid[upd_idx] <= 1'b1;
            end else if (counters[upd_idx] != '0) begin
                counters[upd_idx] <= counters[upd_idx] - 2'd1;
            end
            ghr <= {ghr[GHR_WIDTH-2:0], update_taken};
        end
    end

    // Target written only on taken outcomes
    always_ff @(posedge clock) begin
        if (update_valid && update_taken) begin
            targets[upd_idx] <= update_target;
        end
    end

endmodule

`default_nettype wire

/* hw/stage_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module stage_fetch
    import fetch_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,

    // Instruction memory
    output logic                      read_valid,
    output addr_t                     read_addr0,
    output addr_t                     read_addr1,
    input  line_t                     line0,
    input  line_t                     line1,
    input  logic                      line_ready,

    // Instruction buffer and retire
    input  logic                      ib_full,
    input  logic                      mispredict,
    input  addr_t                     pc_override,

    // Branch predictor
    output logic                      bp_req_valid,
    output addr_t                     bp_req_pc,
    input  logic                      pred_taken,
    input  addr_t                     pred_target,
    input  ghr_t                      pred_ghr,

    // Bundle to the instruction buffer
    output logic                      ib_bundle_valid,
    output addr_t [FETCH_WIDTH-1:0]   fetch_pc,
    output inst_t [FETCH_WIDTH-1:0]   fetch_inst,
    output logic  [FETCH_WIDTH-1:0]   fetch_is_branch,
    output logic  [FETCH_WIDTH-1:0]   fetch_pred_taken,
    output addr_t [FETCH_WIDTH-1:0]   fetch_pred_target,
    output ghr_t  [FETCH_WIDTH-1:0]   fetch_ghr
);

    localparam int    LANE_W       = $clog2(FETCH_WIDTH);
    localparam addr_t BUNDLE_BYTES = addr_t'(FETCH_WIDTH * 4);

    addr_t pc;
    addr_t pc_next;

    // Both lines side by side, lane 0 in the low word
    logic [FETCH_WIDTH*$bits(inst_t)-1:0] window;
    inst_t                                lane_inst [FETCH_WIDTH];

    logic [FETCH_WIDTH-1:0] lane_is_branch;
    logic                   found_branch;
    logic [LANE_W-1:0]      branch_lane;
    logic                   fetch_stall;

    assign window = {line1, line0};

    // ----------------------------------------------------------------------
    // Lane split and earliest-branch search
    // ----------------------------------------------------------------------

    always_comb begin
        found_branch = 1'b0;
        branch_lane  = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_inst[i]      = window[i*$bits(inst_t) +: $bits(inst_t)];
            lane_is_branch[i] = line_ready && (lane_inst[i][6:0] == RV32_BRANCH);
            // Program order, first hit wins
            if (!found_branch && lane_is_branch[i]) begin
                found_branch = 1'b1;
                branch_lane  = LANE_W'(i);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Handshakes
    // ----------------------------------------------------------------------

    assign fetch_stall     = !line_ready || ib_full || mispredict;
    assign ib_bundle_valid = !fetch_stall;

    // No reads under back-pressure or while being redirected
    assign read_valid = !ib_full && !mispredict;
    assign read_addr0 = pc;
    assign read_addr1 = pc + 32'd8;

    assign bp_req_valid = ib_bundle_valid && found_branch;
    assign bp_req_pc    = pc + addr_t'({branch_lane, 2'b00});

    // ----------------------------------------------------------------------
    // Bundle
    // ----------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            fetch_pc[i]          = pc + addr_t'(i * 4);
            fetch_inst[i]        = lane_inst[i];
            fetch_is_branch[i]   = 1'b0;
            fetch_pred_taken[i]  = 1'b0;
            fetch_pred_target[i] = '0;
            fetch_ghr[i]         = '0;
        end
        // Only the chosen branch carries predictor metadata
        if (bp_req_valid) begin
            fetch_is_branch[branch_lane]   = 1'b1;
            fetch_pred_taken[branch_lane]  = pred_taken;
            fetch_pred_target[branch_lane] = pred_target;
            fetch_ghr[branch_lane]         = pred_ghr;
        end
    end

    // ----------------------------------------------------------------------
    // Next PC
    // ----------------------------------------------------------------------

    always_comb begin
        if (mispredict) begin
            pc_next = pc_override;
        end else if (fetch_stall) begin
            pc_next = pc;
        end else if (found_branch && pred_taken) begin
            pc_next = pred_target;
        end else begin
            pc_next = pc + BUNDLE_BYTES;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter int MEM_WORDS  = 256,
    parameter int BP_ENTRIES = 16
) (
    input  logic                      clock,
    input  logic                      reset,

    // Program load
    input  logic                      load_enable,
    input  addr_t                     load_addr,
    input  inst_t                     load_data,

    // Back-pressure and redirect
    input  logic                      ib_full,
    input  logic                      mispredict,
    input  addr_t                     pc_override,

    // Predictor training
    input  logic                      update_valid,
    input  addr_t                     update_pc,
    input  logic                      update_taken,
    input  addr_t                     update_target,

    // Bundle
    output logic                      ib_bundle_valid,
    output addr_t [FETCH_WIDTH-1:0]   fetch_pc,
    output inst_t [FETCH_WIDTH-1:0]   fetch_inst,
    output logic  [FETCH_WIDTH-1:0]   fetch_is_branch,
    output logic  [FETCH_WIDTH-1:0]   fetch_pred_taken,
    output addr_t [FETCH_WIDTH-1:0]   fetch_pred_target,
    output ghr_t  [FETCH_WIDTH-1:0]   fetch_ghr
);

    // Fetch to memory
    logic  read_valid;
    addr_t read_addr0;
    addr_t read_addr1;
    line_t line0;
    line_t line1;
    logic  line_ready;

    // Fetch to predictor
    logic  bp_req_valid;
    addr_t bp_req_pc;
    logic  pred_taken;
    addr_t pred_target;
    ghr_t  pred_ghr;

    inst_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_inst_memory (
        .clock       (clock),
        .reset       (reset),
        .load_enable (load_enable),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .read_valid  (read_valid),
        .read_addr0  (read_addr0),
        .read_addr1  (read_addr1),
        .line0       (line0),
        .line1       (line1),
        .line_ready  (line_ready)
    );

    branch_predictor #(
        .BP_ENTRIES (BP_ENTRIES)
    ) u_branch_predictor (
        .clock         (clock),
        .reset         (reset),
        .bp_req_valid  (bp_req_valid),
        .bp_req_pc     (bp_req_pc),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .pred_ghr      (pred_ghr),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    stage_fetch u_stage_fetch (
        .clock             (clock),
        .reset             (reset),
        .read_valid        (read_valid),
        .read_addr0        (read_addr0),
        .read_addr1        (read_addr1),
        .line0             (line0),
        .line1             (line1),
        .line_ready        (line_ready),
        .ib_full           (ib_full),
        .mispredict        (mispredict),
        .pc_override       (pc_override),
        .bp_req_valid      (bp_req_valid),
        .bp_req_pc         (bp_req_pc),
        .pred_taken        (pred_taken),
        .pred_target       (pred_target),
        .pred_ghr          (pred_ghr),
        .ib_bundle_valid   (ib_bundle_valid),
        .fetch_pc          (fetch_pc),
        .fetch_inst        (fetch_inst),
        .fetch_is_branch   (fetch_is_branch),
        .fetch_pred_taken  (fetch_pred_taken),
        .fetch_pred_target (fetch_pred_target),
        .fetch_ghr         (fetch_ghr)
    );

endmodule

`default_nettype wire

/* verif/fetch_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_checker
    import fetch_pkg::*;
(
    input logic                   clock,
    input logic                   reset,
    input logic [FETCH_WIDTH-1:0] fetch_is_branch,
    input logic                   bp_req_valid,
    input logic                   line_ready,
    input logic                   ib_full,
    input logic                   mispredict,
    input logic                   ib_bundle_valid
);

    int error_count;

    initial begin
        error_count = 0;
    end

    // Only the earliest branch lane carries metadata
    single_branch_lane: assert property (
        @(posedge clock) disable iff (reset) $onehot0(fetch_is_branch)
    ) else begin
        error_count++;
        $error("More than one lane marked as a branch");
    end

    // Predictor is only asked for a bundle that can be delivered
    request_when_ready: assert property (
        @(posedge clock) disable iff (reset) bp_req_valid |-> (line_ready && !ib_full)
    ) else begin
        error_count++;
        $error("Predictor request without a ready line or with ib_full high");
    end

    no_bundle_on_redirect: assert property (
        @(posedge clock) disable iff (reset) !(ib_bundle_valid && mispredict)
    ) else begin
        error_count++;
        $error("Bundle delivered while mispredict was high");
    end

endmodule

`default_nettype wire

/* verif/fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    localparam int MEM_WORDS  = 256;
    localparam int BP_ENTRIES = 16;
    localparam int TIMEOUT    = 50;

    logic  clock;
    logic  reset;
    logic  load_enable;
    addr_t load_addr;
    inst_t load_data;
    logic  ib_full;
    logic  mispredict;
    addr_t pc_override;
    logic  update_valid;
    addr_t update_pc;
    logic  update_taken;
    addr_t update_target;

    logic                    ib_bundle_valid;
    addr_t [FETCH_WIDTH-1:0] fetch_pc;
    inst_t [FETCH_WIDTH-1:0] fetch_inst;
    logic  [FETCH_WIDTH-1:0] fetch_is_branch;
    logic  [FETCH_WIDTH-1:0] fetch_pred_taken;
    addr_t [FETCH_WIDTH-1:0] fetch_pred_target;
    ghr_t  [FETCH_WIDTH-1:0] fetch_ghr;

    // Reference model state
    inst_t      model_mem    [MEM_WORDS];
    logic [1:0] model_ctr    [BP_ENTRIES];
    addr_t      model_target [BP_ENTRIES];
    logic       model_tvalid [BP_ENTRIES];
    ghr_t       model_ghr;
    addr_t      model_pc;

    logic [31:0] rng_state;
    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          redirects;
    int          checker_seen;

    fetch_top #(
        .MEM_WORDS  (MEM_WORDS),
        .BP_ENTRIES (BP_ENTRIES)
    ) dut (.*);

    bind stage_fetch fetch_checker u_fetch_checker (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper bits of the LCG are the better distributed ones
    function automatic int unsigned rand_below(int unsigned n);
        return (next_rand() >> 16) % n;
    endfunction

    function automatic void record_error();
        test_errors++;
        total_errors++;
    endfunction

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    function automatic void train_model(addr_t pc, logic taken, addr_t target);
        int idx;
        idx = (pc >> 2) % BP_ENTRIES;
        if (taken) begin
            if (model_ctr[idx] != 2'd3) begin
                model_ctr[idx]++;
            end
            model_tvalid[idx] = 1'b1;
            model_target[idx] = target;
        end else if (model_ctr[idx] != 2'd0) begin
            model_ctr[idx]--;
        end
        model_ghr = {model_ghr[GHR_WIDTH-2:0], taken};
    endfunction

    task automatic check_field(string field, int lane, logic [31:0] expected,
                               logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s lane %0d %s: expected %h, actual %h",
                     test_name, lane, field, expected, actual);
            record_error();
        end
    endtask

    task automatic check_bundle();
        int    br_lane;
        int    idx;
        logic  exp_taken;
        addr_t exp_target;
        inst_t word;
        logic  mark;
        br_lane    = -1;
        exp_taken  = 1'b0;
        exp_target = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            word = model_mem[((model_pc >> 2) + i) % MEM_WORDS];
            if (br_lane < 0 && word[6:0] == RV32_BRANCH) begin
                br_lane = i;
            end
        end
        if (br_lane >= 0) begin
            idx        = ((model_pc >> 2) + br_lane) % BP_ENTRIES;
            exp_taken  = model_tvalid[idx] && (model_ctr[idx] >= 2'd2);
            exp_target = model_tvalid[idx] ? model_target[idx] : '0;
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            mark = (i == br_lane);
            check_field("pc", i, model_pc + addr_t'(4 * i), fetch_pc[i]);
            check_field("inst", i, model_mem[((model_pc >> 2) + i) % MEM_WORDS],
                        fetch_inst[i]);
            check_field("is_branch", i, mark, fetch_is_branch[i]);
            check_field("pred_taken", i, mark && exp_taken, fetch_pred_taken[i]);
            check_field("pred_target", i, mark ? exp_target : '0, fetch_pred_target[i]);
            check_field("ghr", i, mark ? model_ghr : '0, fetch_ghr[i]);
        end
        if (exp_taken) begin
            model_pc = exp_target;
            redirects++;
        end else begin
            model_pc = model_pc + 32'd16;
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    // branch_odds of 0 gives a program without branches
    task automatic load_program(int unsigned branch_odds);
        inst_t word;
        for (int a = 0; a < MEM_WORDS; a++) begin
            @(posedge clock);
            #1;
            ib_full = 1'b1;
            word    = next_rand();
            if (word[6:0] == RV32_BRANCH) begin
                word[6:0] = 7'b0010011;
            end
            if (branch_odds != 0 && rand_below(branch_odds) == 0) begin
                word[6:0] = RV32_BRANCH;
            end
            load_enable  = 1'b1;
            load_addr    = addr_t'(a * 4);
            load_data    = word;
            model_mem[a] = word;
        end
        @(posedge clock);
        #1;
        load_enable = 1'b0;
    endtask

    // Fetch held off while the predictor learns
    task automatic train(int count);
        addr_t pc;
        logic  taken;
        addr_t target;
        for (int n = 0; n < count; n++) begin
            @(posedge clock);
            #1;
            ib_full       = 1'b1;
            pc            = (next_rand() >> 8) & 32'h3c;
            taken         = (rand_below(4) != 0);
            target        = (next_rand() >> 8) & 32'h3fc;
            update_valid  = 1'b1;
            update_pc     = pc;
            update_taken  = taken;
            update_target = target;
            train_model(pc, taken, target);
        end
        @(posedge clock);
        #1;
        update_valid = 1'b0;
    endtask

    task automatic run_bundles(int count, bit backpressure);
        int seen;
        int idle;
        seen = 0;
        idle = 0;
        while (seen < count && idle < TIMEOUT) begin
            @(posedge clock);
            #1;
            mispredict = 1'b0;
            ib_full    = backpressure ? (rand_below(3) == 0) : 1'b0;
            @(negedge clock);
            if (ib_bundle_valid) begin
                assert (!ib_full) else begin
                    $display("%s: bundle delivered while ib_full was high", test_name);
                    record_error();
                end
                check_bundle();
                seen++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (seen < count) begin
            $display("%s: no bundle arrived within %0d cycles", test_name, TIMEOUT);
            record_error();
        end
    endtask

    task automatic redirect(addr_t target);
        @(posedge clock);
        #1;
        ib_full     = 1'b0;
        mispredict  = 1'b1;
        pc_override = target;
        @(negedge clock);
        assert (!ib_bundle_valid) else begin
            $display("%s: bundle delivered during a mispredict pulse", test_name);
            record_error();
        end
        model_pc = target;
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        int fresh;
        fresh        = dut.u_stage_fetch.u_fetch_checker.error_count - checker_seen;
        checker_seen = checker_seen + fresh;
        test_errors  = test_errors + fresh;
        total_errors = total_errors + fresh;
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        load_enable   = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        ib_full       = 1'b1;
        mispredict    = 1'b0;
        pc_override   = '0;
        update_valid  = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_target = '0;
        rng_state     = 32'h3c78_881a;
        total_errors  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        redirects     = 0;
        checker_seen  = 0;
        model_ghr     = '0;
        model_pc      = '0;
        for (int i = 0; i < BP_ENTRIES; i++) begin
            model_ctr[i]    = 2'd1;
            model_tvalid[i] = 1'b0;
            model_target[i] = '0;
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("sequential_fetch");
        load_program(0);
        run_bundles(24, 1'b0);
        finish_test();

        start_test("branch_marking");
        load_program(4);
        run_bundles(24, 1'b0);
        finish_test();

        start_test("predicted_redirect");
        redirects = 0;
        train(48);
        run_bundles(32, 1'b0);
        assert (redirects > 0) else begin
            $display("%s: no bundle followed a predicted taken branch", test_name);
            record_error();
        end
        finish_test();

        start_test("back_pressure");
        run_bundles(32, 1'b1);
        finish_test();

        start_test("override");
        for (int n = 0; n < 6; n++) begin
            redirect((next_rand() >> 8) & 32'h3fc);
            run_bundles(3, 1'b0);
        end
        finish_test();

        $display("Tests: %0d run, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/fetch_pkg.sv
hw/inst_memory.sv
hw/branch_predictor.sv
hw/stage_fetch.sv
hw/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/inst_memory.sv
      - hw/branch_predictor.sv
      - hw/stage_fetch.sv
      - hw/fetch_top.sv
  - target: simulation
    files:
      - verif/fetch_checker.sv
      - verif/fetch_tb.sv
